/* rtl/neuron_pkg.sv */
package neuron_pkg;

    // input stream, four lanes per beat.
    localparam int PARALLEL = 4;
    localparam int DIN_WIDTH = 16;
    localparam int DIN_POINT = 15;

    localparam int WEIGHT_WIDTH = 16;
    localparam int WEIGHT_POINT = 15;
    localparam int WEIGHT_NUMB = 64;

    localparam int BEATS = WEIGHT_NUMB / PARALLEL;
    localparam int BEAT_ADDR_WIDTH = $clog2(BEATS);

    // products land in Q2.30.
    localparam int ACC_WIDTH = 48;
    localparam int ACC_POINT = DIN_POINT + WEIGHT_POINT;

    // two guard bits for the lane sum.
    localparam int SUM_WIDTH = ACC_WIDTH + $clog2(PARALLEL);

    // activation input is Q2.14.
    localparam int ACT_WIDTH = 16;
    localparam int ACT_INT = 2;

    localparam int ACT_OUT_WIDTH = 16;
    localparam int ACT_OUT_POINT = 15;

    typedef enum logic {
        ctrl_idle,
        ctrl_accumulate
    } ctrl_state_t;

    typedef enum logic {
        act_relu,
        act_hard_sigmoid
    } act_func_t;

endpackage

/* rtl/neuron_control.sv */
`timescale 1ns/10ps

module neuron_control (
    input  logic clk,
    input  logic reset,
    input  logic din_valid,
    input  logic weight_we,
    output logic [neuron_pkg::BEAT_ADDR_WIDTH-1:0] mem_raddr,
    output logic beat_first,
    output logic beat_last,
    output logic mem_we,
    output logic busy
);
    import neuron_pkg::*;

    localparam logic [BEAT_ADDR_WIDTH-1:0] LAST_BEAT = BEAT_ADDR_WIDTH'(BEATS - 1);

    ctrl_state_t state;
    logic [BEAT_ADDR_WIDTH-1:0] beat_count;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ctrl_idle;
            beat_count <= '0;
        end else begin
            case (state)
                ctrl_idle: begin
                    if (din_valid) begin
                        state <= ctrl_accumulate;
                        beat_count <= beat_count + 1'b1;
                    end
                end
                ctrl_accumulate: begin
                    if (din_valid) begin
                        if (beat_last) begin
                            // next beat may open a new vector right away.
                            state <= ctrl_idle;
                            beat_count <= '0;
                        end else begin
                            beat_count <= beat_count + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= ctrl_idle;
                    beat_count <= '0;
                end
            endcase
        end
    end

    // weight row for the beat on the bus now.
    assign mem_raddr = beat_count;

    assign beat_first = din_valid && (beat_count == '0);
    assign beat_last = din_valid && (beat_count == LAST_BEAT);

    // writes during a vector are dropped.
    assign mem_we = weight_we && (state == ctrl_idle);

    assign busy = (state == ctrl_accumulate);

endmodule

/* rtl/weight_memory.sv */
`timescale 1ns/10ps

module weight_memory (
    input  logic clk,
    input  logic mem_we,
    input  logic [neuron_pkg::BEAT_ADDR_WIDTH-1:0] weight_addr,
    input  logic [neuron_pkg::PARALLEL*neuron_pkg::WEIGHT_WIDTH-1:0] weight_data,
    input  logic [neuron_pkg::BEAT_ADDR_WIDTH-1:0] mem_raddr,
    output logic [neuron_pkg::PARALLEL*neuron_pkg::WEIGHT_WIDTH-1:0] weight_word
);
    import neuron_pkg::*;

    // one row per beat, lane 0 in the low bits.
    logic [PARALLEL*WEIGHT_WIDTH-1:0] mem [BEATS];

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[weight_addr] <= weight_data;
        end
    end

    // registered read, old data on a same-row write.
    always_ff @(posedge clk) begin
        weight_word <= mem[mem_raddr];
    end

endmodule

/* rtl/mac_array.sv */
`timescale 1ns/10ps

module mac_array (
    input  logic clk,
    input  logic reset,
    input  logic [neuron_pkg::PARALLEL*neuron_pkg::DIN_WIDTH-1:0] din,
    input  logic din_valid,
    input  logic beat_first,
    input  logic beat_last,
    input  logic signed [neuron_pkg::SUM_WIDTH-1:0] bias,
    input  neuron_pkg::act_func_t act_func,
    input  logic [neuron_pkg::PARALLEL*neuron_pkg::WEIGHT_WIDTH-1:0] weight_word,
    output logic signed [neuron_pkg::SUM_WIDTH-1:0] acc_out,
    output logic acc_valid,
    output logic signed [neuron_pkg::SUM_WIDTH-1:0] acc_bias,
    output neuron_pkg::act_func_t acc_func
);
    import neuron_pkg::*;

    localparam int PROD_WIDTH = DIN_WIDTH + WEIGHT_WIDTH;

    // stage 1, lines up with the weight read.
    logic [PARALLEL*DIN_WIDTH-1:0] din_d;
    logic valid_d;
    logic first_d;
    logic last_d;
    logic signed [SUM_WIDTH-1:0] bias_d;
    act_func_t func_d;

    // stage 2, Q2.30 lane products.
    logic signed [PROD_WIDTH-1:0] prod [PARALLEL];
    logic prod_valid;
    logic prod_first;
    logic prod_last;
    logic signed [SUM_WIDTH-1:0] bias_p;
    act_func_t func_p;

    logic signed [SUM_WIDTH-1:0] lane_sum;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_d <= 1'b0;
            first_d <= 1'b0;
            last_d <= 1'b0;
            prod_valid <= 1'b0;
            prod_first <= 1'b0;
            prod_last <= 1'b0;
            acc_valid <= 1'b0;
        end else begin
            valid_d <= din_valid;
            first_d <= beat_first;
            last_d <= beat_last;
            prod_valid <= valid_d;
            prod_first <= first_d;
            prod_last <= last_d;
            acc_valid <= prod_valid && prod_last; // final sum is out next cycle.
        end
    end

    always_ff @(posedge clk) begin
        din_d <= din;
        bias_d <= bias;
        func_d <= act_func;
        for (int i = 0; i < PARALLEL; i++) begin
            prod[i] <= $signed(din_d[i*DIN_WIDTH +: DIN_WIDTH])
                     * $signed(weight_word[i*WEIGHT_WIDTH +: WEIGHT_WIDTH]);
        end
        bias_p <= bias_d;
        func_p <= func_d;
    end

    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < PARALLEL; i++) begin
            lane_sum = lane_sum + SUM_WIDTH'(prod[i]);
        end
    end

    // stage 3, accumulate.
    always_ff @(posedge clk) begin
        if (prod_valid) begin
            if (prod_first) begin
                acc_out <= lane_sum; // fresh vector.
                acc_bias <= bias_p;
                acc_func <= func_p;
            end else begin
                acc_out <= acc_out + lane_sum;
            end
        end
    end

endmodule

/* rtl/bias_cast.sv */
`timescale 1ns/10ps

module bias_cast (
    input  logic clk,
    input  logic reset,
    input  logic signed [neuron_pkg::SUM_WIDTH-1:0] acc_out,
    input  logic acc_valid,
    input  logic signed [neuron_pkg::SUM_WIDTH-1:0] acc_bias,
    input  neuron_pkg::act_func_t acc_func,
    output logic signed [neuron_pkg::ACT_WIDTH-1:0] cast_out,
    output logic cast_valid,
    output neuron_pkg::act_func_t cast_func
);
    import neuron_pkg::*;

    localparam int ACT_POINT = ACT_WIDTH - ACT_INT;
    localparam int DROP = ACC_POINT - ACT_POINT;
    localparam int WIDE = SUM_WIDTH + 1;
    localparam logic signed [WIDE-1:0] CAST_MAX = WIDE'(2 ** (ACT_WIDTH - 1) - 1);
    localparam logic signed [WIDE-1:0] CAST_MIN = WIDE'(-(2 ** (ACT_WIDTH - 1)));

    logic signed [WIDE-1:0] biased;
    logic signed [WIDE-1:0] floored;
    logic signed [ACT_WIDTH-1:0] sat;

    always_comb begin
        biased = WIDE'(acc_out) + WIDE'(acc_bias); // extra bit, no wrap.
        floored = biased >>> DROP; // rounds toward minus infinity.
        if (floored > CAST_MAX) begin
            sat = ACT_WIDTH'(CAST_MAX);
        end else if (floored < CAST_MIN) begin
            sat = ACT_WIDTH'(CAST_MIN);
        end else begin
            sat = ACT_WIDTH'(floored);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cast_valid <= 1'b0;
        end else begin
            cast_valid <= acc_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (acc_valid) begin
            cast_out <= sat;
            cast_func <= acc_func;
        end
    end

endmodule

/* rtl/activation_unit.sv */
`timescale 1ns/10ps

module activation_unit (
    input  logic clk,
    input  logic reset,
    input  logic signed [neuron_pkg::ACT_WIDTH-1:0] cast_out,
    input  logic cast_valid,
    input  neuron_pkg::act_func_t cast_func,
    output logic [neuron_pkg::ACT_OUT_WIDTH-1:0] dout,
    output logic dout_valid
);
    import neuron_pkg::*;

    localparam int ACT_POINT = ACT_WIDTH - ACT_INT;
    localparam int UP = ACT_OUT_POINT - ACT_POINT; // Q2.14 to Q1.15.
    localparam int WIDE = ACT_WIDTH + 2;
    localparam logic signed [WIDE-1:0] OUT_MAX = WIDE'(2 ** ACT_OUT_POINT - 1);
    localparam logic signed [WIDE-1:0] HALF = WIDE'(2 ** (ACT_OUT_POINT - 1));

    logic signed [WIDE-1:0] x;
    logic signed [WIDE-1:0] y;
    logic [ACT_OUT_WIDTH-1:0] result;

    always_comb begin
        x = WIDE'(cast_out);
        if (cast_func == act_hard_sigmoid) begin
            // x/4 + 0.5, the quarter folded into the format shift.
            y = (x >>> (2 - UP)) + HALF;
        end else begin
            y = x <<< UP;
        end
        // relu negatives fall out here too.
        if (y < 0) begin
            result = '0;
        end else if (y > OUT_MAX) begin
            result = ACT_OUT_WIDTH'(OUT_MAX);
        end else begin
            result = ACT_OUT_WIDTH'(y);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= cast_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cast_valid) begin
            dout <= result;
        end
    end

endmodule

/* rtl/neuron.sv */
`timescale 1ns/10ps

module neuron (
    input  logic clk,
    input  logic reset,
    input  logic [neuron_pkg::PARALLEL*neuron_pkg::DIN_WIDTH-1:0] din,
    input  logic din_valid,
    input  logic signed [neuron_pkg::SUM_WIDTH-1:0] bias,
    input  neuron_pkg::act_func_t act_func,
    input  logic weight_we,
    input  logic [neuron_pkg::BEAT_ADDR_WIDTH-1:0] weight_addr,
    input  logic [neuron_pkg::PARALLEL*neuron_pkg::WEIGHT_WIDTH-1:0] weight_data,
    output logic busy,
    output logic [neuron_pkg::ACT_OUT_WIDTH-1:0] dout,
    output logic dout_valid
);
    import neuron_pkg::*;

    logic [BEAT_ADDR_WIDTH-1:0] mem_raddr;
    logic beat_first;
    logic beat_last;
    logic mem_we;
    logic [PARALLEL*WEIGHT_WIDTH-1:0] weight_word;

    logic signed [SUM_WIDTH-1:0] acc_out;
    logic acc_valid;
    logic signed [SUM_WIDTH-1:0] acc_bias;
    act_func_t acc_func;

    logic signed [ACT_WIDTH-1:0] cast_out;
    logic cast_valid;
    act_func_t cast_func;

    neuron_control u_control (
        .clk        (clk),
        .reset      (reset),
        .din_valid  (din_valid),
        .weight_we  (weight_we),
        .mem_raddr  (mem_raddr),
        .beat_first (beat_first),
        .beat_last  (beat_last),
        .mem_we     (mem_we),
        .busy       (busy)
    );

    weight_memory u_weights (
        .clk         (clk),
        .mem_we      (mem_we),
        .weight_addr (weight_addr),
        .weight_data (weight_data),
        .mem_raddr   (mem_raddr),
        .weight_word (weight_word)
    );

    mac_array u_mac (
        .clk         (clk),
        .reset       (reset),
        .din         (din),
        .din_valid   (din_valid),
        .beat_first  (beat_first),
        .beat_last   (beat_last),
        .bias        (bias),
        .act_func    (act_func),
        .weight_word (weight_word),
        .acc_out     (acc_out),
        .acc_valid   (acc_valid),
        .acc_bias    (acc_bias),
        .acc_func    (acc_func)
    );

    bias_cast u_cast (
        .clk        (clk),
        .reset      (reset),
        .acc_out    (acc_out),
        .acc_valid  (acc_valid),
        .acc_bias   (acc_bias),
        .acc_func   (acc_func),
        .cast_out   (cast_out),
        .cast_valid (cast_valid),
        .cast_func  (cast_func)
    );

    activation_unit u_act (
        .clk        (clk),
        .reset      (reset),
        .cast_out   (cast_out),
        .cast_valid (cast_valid),
        .cast_func  (cast_func),
        .dout       (dout),
        .dout_valid (dout_valid)
    );

endmodule

/* verification/clock_gen.sv */
`timescale 1ns/10ps

module clock_gen (
    output logic clk,
    output logic reset
);

    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period.
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* verification/neuron_asserts.sv */
`timescale 1ns/10ps

module neuron_asserts (
    input logic clk,
    input logic reset,
    input logic beat_last,
    input logic busy,
    input logic dout_valid
);

    // memory read, product, accumulate, cast, activation.
    localparam int LATENCY = 5;

    result_after_last: assert property (
        @(posedge clk) disable iff (reset) beat_last |-> ##LATENCY dout_valid
    ) else $error("dout_valid did not rise five cycles after a last beat");

    no_stray_result: assert property (
        @(posedge clk) disable iff (reset) dout_valid |-> $past(beat_last, LATENCY)
    ) else $error("dout_valid rose without a last beat five cycles before");

    quiet_in_reset: assert property (
        @(posedge clk) reset |=> (!busy && !dout_valid)
    ) else $error("busy or dout_valid high while in reset");

    // two results in a row need two last beats in a row.
    single_cycle_result: assert property (
        @(posedge clk) disable iff (reset)
        (dout_valid && $past(dout_valid))
            |-> ($past(beat_last, LATENCY) && $past(beat_last, LATENCY + 1))
    ) else $error("dout_valid held for two cycles without two last beats");

endmodule

bind neuron neuron_asserts u_asserts (
    .clk        (clk),
    .reset      (reset),
    .beat_last  (beat_last),
    .busy       (busy),
    .dout_valid (dout_valid)
);

/* verification/neuron_tb.sv */
`timescale 1ns/10ps

module neuron_tb;
    import neuron_pkg::*;

    localparam logic [31:0] LFSR_SEED = 32'd7;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam int TOTAL_VECTORS = 38;
    localparam int WATCHDOG_CYCLES = TOTAL_VECTORS * 25 + 600;

    logic clk;
    logic reset;
    logic [PARALLEL*DIN_WIDTH-1:0] din;
    logic din_valid;
    logic signed [SUM_WIDTH-1:0] bias;
    act_func_t act_func;
    logic weight_we;
    logic [BEAT_ADDR_WIDTH-1:0] weight_addr;
    logic [PARALLEL*WEIGHT_WIDTH-1:0] weight_data;
    logic busy;
    logic [ACT_OUT_WIDTH-1:0] dout;
    logic dout_valid;

    logic [31:0] lfsr_state = LFSR_SEED;
    logic [31:0] vector_seed [4];
    logic signed [WEIGHT_WIDTH-1:0] weights [WEIGHT_NUMB];
    logic signed [DIN_WIDTH-1:0] vec_in [WEIGHT_NUMB];
    logic [ACT_OUT_WIDTH-1:0] expected_q [$];
    string current_test;
    int error_count = 0;
    int result_count = 0;
    int errors_at_start;
    int results_at_start;

    clock_gen u_clock (.clk(clk), .reset(reset));

    neuron dut (.*);

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    function automatic longint rand_bits(input int n);
        longint v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | longint'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state); // one step per bit.
        end
        return v;
    endfunction

    function automatic longint rand_signed(input int n);
        longint v;
        v = rand_bits(n);
        return v[n-1] ? v - (longint'(1) << n) : v;
    endfunction

    function automatic act_func_t rand_func();
        return (rand_bits(1) == 1) ? act_hard_sigmoid : act_relu;
    endfunction

    // dot product, bias, floor to Q2.14, saturate, then activation.
    function automatic logic [ACT_OUT_WIDTH-1:0] model_output(input longint bias_val,
                                                              input act_func_t f);
        longint x;
        longint y;
        x = bias_val;
        for (int i = 0; i < WEIGHT_NUMB; i++) begin
            x = x + longint'(vec_in[i]) * longint'(weights[i]);
        end
        x = x >>> 16;
        if (x > 32767) begin
            x = 32767;
        end else if (x < -32768) begin
            x = -32768;
        end
        y = (f == act_relu) ? 2 * x : (x >>> 1) + 16384;
        if (y < 0) begin
            y = 0;
        end else if (y > 32767) begin
            y = 32767;
        end
        return y[ACT_OUT_WIDTH-1:0];
    endfunction

    function automatic void set_vector(input bit use_random, input int width,
                                       input logic signed [DIN_WIDTH-1:0] value);
        for (int i = 0; i < WEIGHT_NUMB; i++) begin
            vec_in[i] = use_random ? DIN_WIDTH'(rand_signed(width)) : value;
        end
    endfunction

    task automatic set_weights(input bit use_random,
                               input logic signed [WEIGHT_WIDTH-1:0] value);
        logic [PARALLEL*WEIGHT_WIDTH-1:0] row;
        for (int i = 0; i < WEIGHT_NUMB; i++) begin
            weights[i] = use_random ? WEIGHT_WIDTH'(rand_bits(WEIGHT_WIDTH)) : value;
        end
        for (int r = 0; r < BEATS; r++) begin
            for (int k = 0; k < PARALLEL; k++) begin
                row[k*WEIGHT_WIDTH +: WEIGHT_WIDTH] = weights[r*PARALLEL + k];
            end
            @(posedge clk);
            weight_we <= 1'b1;
            weight_addr <= BEAT_ADDR_WIDTH'(r);
            weight_data <= row;
        end
        @(posedge clk);
        weight_we <= 1'b0;
    endtask

    task automatic send_vector(input longint bias_val, input act_func_t f,
                               input bit gaps, input bit bad_write);
        logic [PARALLEL*DIN_WIDTH-1:0] word;
        expected_q.push_back(model_output(bias_val, f));
        for (int b = 0; b < BEATS; b++) begin
            for (int k = 0; k < PARALLEL; k++) begin
                word[k*DIN_WIDTH +: DIN_WIDTH] = vec_in[b*PARALLEL + k];
            end
            if (gaps) begin
                repeat (int'(rand_bits(2))) begin
                    @(posedge clk);
                    din_valid <= 1'b0;
                end
            end
            @(posedge clk);
            din <= word;
            din_valid <= 1'b1;
            bias <= SUM_WIDTH'(bias_val);
            act_func <= f;
            weight_we <= bad_write && b == BEATS / 2;
            if (bad_write && b == BEATS / 2) begin
                assert (busy) else begin
                    error_count++;
                    $display("weight write was meant to hit a busy neuron but busy was low");
                end
                weight_addr <= BEAT_ADDR_WIDTH'(rand_bits(BEAT_ADDR_WIDTH));
                weight_data <= (PARALLEL*WEIGHT_WIDTH)'(rand_bits(64));
            end
        end
    endtask

    task automatic start_test(input string name);
        current_test = name;
        errors_at_start = error_count;
        results_at_start = result_count;
    endtask

    task automatic finish_test();
        @(posedge clk);
        din_valid <= 1'b0;
        weight_we <= 1'b0;
        while (expected_q.size() != 0) @(posedge clk);
        $display("test %0s: %0d results, %0d errors", current_test,
                 result_count - results_at_start, error_count - errors_at_start);
    endtask

    task automatic check_result();
        logic [ACT_OUT_WIDTH-1:0] exp;
        result_count++;
        assert (expected_q.size() != 0) else begin
            error_count++;
            $display("result %0d arrived with no vector outstanding", dout);
        end
        if (expected_q.size() != 0) begin
            exp = expected_q.pop_front();
            assert (dout == exp) else begin
                error_count++;
                $display("error %0s: expected %0d, actual %0d", current_test, exp, dout);
            end
        end
    endtask

    always @(posedge clk) begin
        if (!reset && dout_valid) begin
            check_result();
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: run still going after %0d cycles", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        din = '0;
        din_valid = 1'b0;
        bias = '0;
        act_func = act_relu;
        weight_we = 1'b0;
        weight_addr = '0;
        weight_data = '0;
        @(negedge reset);

        start_test("relu_half_weights");
        set_weights(1'b0, 16'sd16384); // 0.5 in Q1.15.
        set_vector(1'b0, 0, 16'sd100);
        send_vector(0, act_relu, 1'b0, 1'b0);
        set_vector(1'b0, 0, -16'sd200);
        send_vector(0, act_relu, 1'b0, 1'b0);
        set_vector(1'b1, 9, '0);
        send_vector(0, act_relu, 1'b0, 1'b0);
        finish_test();

        start_test("random_back_to_back");
        set_weights(1'b1, '0);
        repeat (20) begin
            set_vector(1'b1, 12, '0);
            send_vector(rand_signed(32), rand_func(), 1'b0, 1'b0);
        end
        finish_test();

        start_test("saturation");
        set_weights(1'b0, 16'sh7fff);
        set_vector(1'b0, 0, 16'sh7fff);
        send_vector(0, act_relu, 1'b0, 1'b0);
        send_vector(0, act_hard_sigmoid, 1'b0, 1'b0);
        set_vector(1'b0, 0, 16'sh8000);
        send_vector(0, act_hard_sigmoid, 1'b0, 1'b0);
        send_vector(0, act_relu, 1'b0, 1'b0);
        finish_test();

        // same vectors twice, replayed from saved lfsr states.
        start_test("gapped_beats");
        set_weights(1'b1, '0);
        for (int v = 0; v < 4; v++) begin
            vector_seed[v] = lfsr_state;
            set_vector(1'b1, 12, '0);
            send_vector(rand_signed(32), rand_func(), 1'b0, 1'b0);
        end
        for (int v = 0; v < 4; v++) begin
            lfsr_state = vector_seed[v];
            set_vector(1'b1, 12, '0);
            send_vector(rand_signed(32), rand_func(), 1'b1, 1'b0);
        end
        finish_test();

        start_test("write_while_busy");
        set_weights(1'b1, '0);
        set_vector(1'b1, 12, '0);
        send_vector(rand_signed(32), act_relu, 1'b0, 1'b1);
        repeat (2) begin
            set_vector(1'b1, 12, '0);
            send_vector(rand_signed(32), rand_func(), 1'b0, 1'b0);
        end
        finish_test();

        assert (result_count == TOTAL_VECTORS) else begin
            error_count++;
            $display("%0d results seen for %0d vectors sent", result_count, TOTAL_VECTORS);
        end
        $display("tests 5, results %0d, errors %0d", result_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* neuron.f */
rtl/neuron_pkg.sv
rtl/neuron_control.sv
rtl/weight_memory.sv
rtl/mac_array.sv
rtl/bias_cast.sv
rtl/activation_unit.sv
rtl/neuron.sv
verification/clock_gen.sv
verification/neuron_asserts.sv
verification/neuron_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f neuron.f --top-module neuron_tb -Mdir obj_dir
	./obj_dir/Vneuron_tb | tee $(LOG)
	@! grep -q "Done: errors found" $(LOG)
	@grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
